// File: hw/hyper_bus_pkg.sv
package hyper_bus_pkg;

    localparam int BURST_WIDTH = 8;

    // one word per clk0 cycle, both bus edges folded into it
    typedef logic [15:0]            hyper_word_t;
    typedef logic [1:0]             hyper_mask_t;  // high bit masks that byte
    typedef logic [47:0]            hyper_ca_t;
    typedef logic [BURST_WIDTH-1:0] burst_len_t;   // words minus one
    typedef logic [3:0]             lat_cnt_t;

    localparam int CA_WORDS = 3;

    // read buffer sizing
    localparam int RD_BUF_DEPTH  = 4;
    localparam int RD_CREDIT_MIN = 2;  // one word in flight plus the one being clocked

    typedef enum logic [2:0] {
        IDLE,
        CMD_ADDR,
        LATENCY_X2,
        LATENCY,
        DATA_W,
        DATA_R,
        RECOVERY
    } seq_state_t;

endpackage

// File: hw/hyper_host_pkg.sv
package hyper_host_pkg;

    // one host transaction
    typedef struct packed {
        logic [31:0]               address;        // word address
        logic                      write;
        hyper_bus_pkg::burst_len_t burst;
        logic                      burst_type;     // 1 = linear
        logic                      address_space;  // 0 = memory array
    } hyper_trans_t;

    // runtime timing, held static while busy
    typedef struct packed {
        hyper_bus_pkg::lat_cnt_t t_latency_access;
        logic                    en_latency_additional;
        hyper_bus_pkg::lat_cnt_t t_read_write_recovery;
    } hyper_cfg_t;

    typedef struct packed {
        hyper_bus_pkg::hyper_word_t data;
        hyper_bus_pkg::hyper_mask_t mask;
    } hyper_wdata_t;

    typedef struct packed {
        hyper_bus_pkg::hyper_word_t data;
        logic                       last;  // final word of the burst
    } hyper_rdata_t;

endpackage

// File: hw/hyper_cmd_addr.sv
`timescale 1ns/1ns

module hyper_cmd_addr (
    input  logic                         clk0,
    input  logic                         rst_ni,
    input  hyper_host_pkg::hyper_trans_t trans_i,
    input  logic                         load_i,
    input  logic                         advance_i,
    output hyper_host_pkg::hyper_trans_t trans_o,
    output hyper_bus_pkg::hyper_word_t   ca_word_o
);
    import hyper_bus_pkg::*;

    hyper_ca_t  ca;
    logic [1:0] word_idx_q;  // CA_WORDS means nothing left to send

    always_ff @(posedge clk0) begin
        if (load_i) begin
            trans_o <= trans_i;
        end
    end

    // r/w, space, burst type, upper address, reserved, low address bits
    assign ca = {~trans_o.write, trans_o.address_space, trans_o.burst_type,
                 trans_o.address[31:3], 13'd0, trans_o.address[2:0]};

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            word_idx_q <= 2'(CA_WORDS);
        end else if (load_i) begin
            word_idx_q <= '0;
        end else if (advance_i) begin
            word_idx_q <= word_idx_q + 1'b1;
        end
    end

    always_comb begin
        case (word_idx_q)
            2'd0:    ca_word_o = ca[47:32];
            2'd1:    ca_word_o = ca[31:16];
            2'd2:    ca_word_o = ca[15:0];
            default: ca_word_o = '0;  // bus quiet between commands
        endcase
    end

    // sequencer must not step past the last command/address word
    a_ca_advance_bound : assert property (@(posedge clk0) disable iff (!rst_ni)
        advance_i |-> word_idx_q < 2'(CA_WORDS))
        else $error("command/address advanced more than CA_WORDS times");

endmodule

// File: hw/hyper_sequencer.sv
`timescale 1ns/1ns

module hyper_sequencer (
    input  logic                         clk0,
    input  logic                         rst_ni,
    input  hyper_host_pkg::hyper_cfg_t   cfg_i,
    input  logic                         trans_valid_i,
    output logic                         trans_ready_o,
    input  hyper_host_pkg::hyper_trans_t trans_i,
    input  logic                         tx_valid_i,
    output logic                         tx_ready_o,
    output logic                         b_valid_o,
    output logic                         ca_load_o,
    output logic                         ca_advance_o,
    input  logic                         rwds_i,
    input  logic [2:0]                   rd_credits_i,
    output logic                         rd_capture_en_o,
    output logic                         rd_last_tag_o,
    output logic                         cs_no,
    output logic                         ck_en_o,
    output logic                         dq_oe_o,
    output logic                         rwds_oe_o,
    output logic                         write_mode_o
);
    import hyper_bus_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;
    lat_cnt_t   lat_cnt_q;
    lat_cnt_t   lat_cnt_d;
    burst_len_t burst_cnt_q;
    burst_len_t burst_cnt_d;
    logic       rwds_hi_q;  // memory asked for extra latency
    logic       rd_req;

    always_comb begin
        state_d       = state_q;
        lat_cnt_d     = lat_cnt_q;
        burst_cnt_d   = burst_cnt_q;
        trans_ready_o = 1'b0;
        tx_ready_o    = 1'b0;
        b_valid_o     = 1'b0;
        ca_load_o     = 1'b0;
        ca_advance_o  = 1'b0;
        ck_en_o       = 1'b0;
        rd_req        = 1'b0;

        case (state_q)
            IDLE: begin
                if (trans_valid_i) begin
                    trans_ready_o = 1'b1;
                    ca_load_o     = 1'b1;
                    lat_cnt_d     = lat_cnt_t'(CA_WORDS - 1);
                    state_d       = CMD_ADDR;
                end
            end
            CMD_ADDR: begin
                ck_en_o      = 1'b1;
                ca_advance_o = 1'b1;
                lat_cnt_d    = lat_cnt_q - 1'b1;
                if (lat_cnt_q == '0) begin
                    lat_cnt_d = cfg_i.t_latency_access - 1'b1;
                    state_d   = (rwds_hi_q || cfg_i.en_latency_additional) ? LATENCY_X2
                                                                           : LATENCY;
                end
            end
            LATENCY_X2: begin
                ck_en_o   = 1'b1;
                lat_cnt_d = lat_cnt_q - 1'b1;
                if (lat_cnt_q == '0) begin
                    lat_cnt_d = cfg_i.t_latency_access - 1'b1;
                    state_d   = LATENCY;
                end
            end
            LATENCY: begin
                ck_en_o   = 1'b1;
                lat_cnt_d = lat_cnt_q - 1'b1;
                if (lat_cnt_q == '0) begin
                    burst_cnt_d = trans_i.burst;
                    state_d     = trans_i.write ? DATA_W : DATA_R;
                end
            end
            DATA_W: begin
                tx_ready_o = 1'b1;
                ck_en_o    = tx_valid_i;  // no beat, no clock
                if (tx_valid_i) begin
                    burst_cnt_d = burst_cnt_q - 1'b1;
                    if (burst_cnt_q == '0) begin
                        b_valid_o = 1'b1;
                        lat_cnt_d = cfg_i.t_read_write_recovery - 1'b1;
                        state_d   = RECOVERY;
                    end
                end
            end
            DATA_R: begin
                // only clock a word the buffer can still take
                if (rd_credits_i >= 3'(RD_CREDIT_MIN)) begin
                    ck_en_o     = 1'b1;
                    rd_req      = 1'b1;
                    burst_cnt_d = burst_cnt_q - 1'b1;
                    if (burst_cnt_q == '0) begin
                        lat_cnt_d = cfg_i.t_read_write_recovery - 1'b1;
                        state_d   = RECOVERY;
                    end
                end
            end
            RECOVERY: begin
                lat_cnt_d = lat_cnt_q - 1'b1;
                if (lat_cnt_q == '0) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign write_mode_o = (state_q == DATA_W);

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q         <= IDLE;
            lat_cnt_q       <= '0;
            burst_cnt_q     <= '0;
            rwds_hi_q       <= 1'b0;
            cs_no           <= 1'b1;
            dq_oe_o         <= 1'b0;
            rwds_oe_o       <= 1'b0;
            rd_capture_en_o <= 1'b0;
            rd_last_tag_o   <= 1'b0;
        end else begin
            state_q     <= state_d;
            lat_cnt_q   <= lat_cnt_d;
            burst_cnt_q <= burst_cnt_d;
            // rwds is valid on the second command/address word
            if (state_q == CMD_ADDR && lat_cnt_q == lat_cnt_t'(CA_WORDS - 2)) begin
                rwds_hi_q <= rwds_i;
            end
            cs_no     <= (state_d == IDLE) || (state_d == RECOVERY);
            dq_oe_o   <= (state_d == CMD_ADDR) || (state_d == DATA_W);
            rwds_oe_o <= (state_d == DATA_W);
            // memory answers one cycle after each clocked request
            rd_capture_en_o <= rd_req;
            rd_last_tag_o   <= rd_req && (burst_cnt_q == '0);
        end
    end

    a_dq_oe_needs_cs : assert property (@(posedge clk0) disable iff (!rst_ni)
        $rose(dq_oe_o) |-> !cs_no)
        else $error("dq driven while chip select inactive");

    // a clocked read word still finds a free entry when it comes back
    a_rd_clk_credits : assert property (@(posedge clk0) disable iff (!rst_ni)
        (state_q == DATA_R) && ck_en_o |=> rd_credits_i != '0)
        else $error("read word returned with no free buffer entry");

endmodule

// File: hw/hyper_read_path.sv
`timescale 1ns/1ns

module hyper_read_path (
    input  logic                         clk0,
    input  logic                         rst_ni,
    input  logic                         capture_en_i,
    input  logic                         last_tag_i,
    input  logic                         hyper_rwds_i,
    input  hyper_bus_pkg::hyper_word_t   hyper_dq_i,
    output hyper_host_pkg::hyper_rdata_t rx_o,
    output logic                         rx_valid_o,
    input  logic                         rx_ready_i,
    output logic [2:0]                   credits_o
);
    import hyper_bus_pkg::*;
    import hyper_host_pkg::*;

    hyper_rdata_t                    rd_buf [RD_BUF_DEPTH];
    logic [$clog2(RD_BUF_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(RD_BUF_DEPTH)-1:0] rd_ptr_q;
    logic [2:0]                      count_q;
    logic                            push;
    logic                            pop;

    assign push       = capture_en_i && hyper_rwds_i;  // rwds marks a valid word
    assign pop        = rx_valid_o && rx_ready_i;
    assign rx_valid_o = (count_q != '0);
    assign rx_o       = rd_buf[rd_ptr_q];
    assign credits_o  = 3'(RD_BUF_DEPTH) - count_q;

    always_ff @(posedge clk0) begin
        if (push) begin
            rd_buf[wr_ptr_q].data <= hyper_dq_i;
            rd_buf[wr_ptr_q].last <= last_tag_i;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // credit gating upstream has to keep this from ever overflowing
    a_no_push_full : assert property (@(posedge clk0) disable iff (!rst_ni)
        push |-> count_q < 3'(RD_BUF_DEPTH))
        else $error("read buffer written while full");

endmodule

// File: hw/hyper_phy.sv
`timescale 1ns/1ns

module hyper_phy (
    input  logic                         clk0,
    input  logic                         rst_ni,
    input  hyper_host_pkg::hyper_cfg_t   cfg_i,
    input  hyper_host_pkg::hyper_trans_t trans_i,
    input  logic                         trans_valid_i,
    output logic                         trans_ready_o,
    input  hyper_host_pkg::hyper_wdata_t tx_i,
    input  logic                         tx_valid_i,
    output logic                         tx_ready_o,
    output hyper_host_pkg::hyper_rdata_t rx_o,
    output logic                         rx_valid_o,
    input  logic                         rx_ready_i,
    output logic                         b_valid_o,
    output logic                         hyper_cs_no,
    output logic                         hyper_ck_en_o,   // qualifies the board clock
    output hyper_bus_pkg::hyper_word_t   hyper_dq_o,
    output logic                         hyper_dq_oe_o,
    output hyper_bus_pkg::hyper_mask_t   hyper_rwds_o,    // one bit per byte
    output logic                         hyper_rwds_oe_o,
    input  hyper_bus_pkg::hyper_word_t   hyper_dq_i,
    input  logic                         hyper_rwds_i,
    output logic                         hyper_reset_no
);
    import hyper_bus_pkg::*;
    import hyper_host_pkg::*;

    hyper_trans_t trans_q;
    hyper_word_t  ca_word;
    logic         ca_load;
    logic         ca_advance;
    logic         write_mode;
    logic         rd_capture_en;
    logic         rd_last_tag;
    logic [2:0]   rd_credits;

    assign hyper_reset_no = rst_ni;

    // write data replaces the command/address word once the burst starts
    assign hyper_dq_o   = write_mode ? tx_i.data : ca_word;
    assign hyper_rwds_o = write_mode ? tx_i.mask : '0;

    hyper_cmd_addr u_cmd_addr (
        .clk0      (clk0),
        .rst_ni    (rst_ni),
        .trans_i   (trans_i),
        .load_i    (ca_load),
        .advance_i (ca_advance),
        .trans_o   (trans_q),
        .ca_word_o (ca_word)
    );

    hyper_sequencer u_sequencer (
        .clk0            (clk0),
        .rst_ni          (rst_ni),
        .cfg_i           (cfg_i),
        .trans_valid_i   (trans_valid_i),
        .trans_ready_o   (trans_ready_o),
        .trans_i         (trans_q),
        .tx_valid_i      (tx_valid_i),
        .tx_ready_o      (tx_ready_o),
        .b_valid_o       (b_valid_o),
        .ca_load_o       (ca_load),
        .ca_advance_o    (ca_advance),
        .rwds_i          (hyper_rwds_i),
        .rd_credits_i    (rd_credits),
        .rd_capture_en_o (rd_capture_en),
        .rd_last_tag_o   (rd_last_tag),
        .cs_no           (hyper_cs_no),
        .ck_en_o         (hyper_ck_en_o),
        .dq_oe_o         (hyper_dq_oe_o),
        .rwds_oe_o       (hyper_rwds_oe_o),
        .write_mode_o    (write_mode)
    );

    hyper_read_path u_read_path (
        .clk0         (clk0),
        .rst_ni       (rst_ni),
        .capture_en_i (rd_capture_en),
        .last_tag_i   (rd_last_tag),
        .hyper_rwds_i (hyper_rwds_i),
        .hyper_dq_i   (hyper_dq_i),
        .rx_o         (rx_o),
        .rx_valid_o   (rx_valid_o),
        .rx_ready_i   (rx_ready_i),
        .credits_o    (rd_credits)
    );

endmodule

// File: testbench/hyper_ram_model.sv
`timescale 1ns/1ns

module hyper_ram_model (
    input  logic                       clk0,
    input  logic                       cs_ni,
    input  logic                       ck_en_i,
    input  hyper_bus_pkg::hyper_word_t dq_i,
    input  hyper_bus_pkg::hyper_mask_t mask_i,
    input  hyper_bus_pkg::lat_cnt_t    lat_i,
    input  logic                       add_lat_i,
    output hyper_bus_pkg::hyper_word_t dq_o,
    output logic                       rwds_o
);
    import hyper_bus_pkg::*;

    hyper_word_t mem [256];
    logic [7:0]  addr_q;
    logic        read_q;
    logic        dbl_q;      // two latency periods
    logic        rd_rwds_q;
    hyper_word_t rd_data_q;
    int          clk_cnt;
    int          data_start;

    initial begin
        for (int a = 0; a < 256; a++) begin
            mem[a] = {8'(a) ^ 8'h5a, 8'(a)};
        end
        clk_cnt   = 0;
        rd_rwds_q = 1'b0;
        rd_data_q = '0;
    end

    assign data_start = CA_WORDS + (dbl_q ? 2 : 1) * int'(lat_i);

    // address bit 4 sits at bit 1 of the second command word
    assign rwds_o = (!cs_ni && clk_cnt == 1) ? dq_i[1] : rd_rwds_q;
    assign dq_o   = rd_data_q;

    always @(posedge clk0) begin
        rd_rwds_q <= 1'b0;
        if (cs_ni) begin
            clk_cnt <= 0;
        end else if (ck_en_i) begin
            clk_cnt <= clk_cnt + 1;
            if (clk_cnt == 0) begin
                read_q <= dq_i[15];
            end else if (clk_cnt == 1) begin
                addr_q[7:3] <= dq_i[4:0];
                dbl_q       <= dq_i[1] || add_lat_i;
            end else if (clk_cnt == 2) begin
                addr_q[2:0] <= dq_i[2:0];
            end else if (clk_cnt >= data_start) begin
                addr_q <= addr_q + 8'd1;  // linear burst
                if (read_q) begin
                    rd_data_q <= mem[addr_q];
                    rd_rwds_q <= 1'b1;
                end else begin
                    if (!mask_i[1]) begin
                        mem[addr_q][15:8] <= dq_i[15:8];
                    end
                    if (!mask_i[0]) begin
                        mem[addr_q][7:0] <= dq_i[7:0];
                    end
                end
            end
        end
    end

endmodule

// File: testbench/tb_hyper_phy.sv
`timescale 1ns/1ns

module tb_hyper_phy;
    import hyper_bus_pkg::*;
    import hyper_host_pkg::*;

    logic         clk0;
    logic         rst_ni;
    hyper_cfg_t   cfg_i;
    hyper_trans_t trans_i;
    logic         trans_valid_i;
    logic         trans_ready_o;
    hyper_wdata_t tx_i;
    logic         tx_valid_i;
    logic         tx_ready_o;
    hyper_rdata_t rx_o;
    logic         rx_valid_o;
    logic         rx_ready_i;
    logic         b_valid_o;
    logic         hyper_cs_no;
    logic         hyper_ck_en_o;
    hyper_word_t  hyper_dq_o;
    logic         hyper_dq_oe_o;
    hyper_mask_t  hyper_rwds_o;
    logic         hyper_rwds_oe_o;
    hyper_word_t  hyper_dq_i;
    logic         hyper_rwds_i;
    logic         hyper_reset_no;

    logic [31:0] golden [256];
    integer      seed = 32'he51271f3;
    int          cycles = 0;
    int          cycle_limit = 200;
    int          ready_pulses = 0;
    int          cs_high_cnt = 0;
    lat_cnt_t    rec_need = '0;  // recovery owed by the last transaction

    hyper_phy u_hyper_phy (.*);

    hyper_ram_model u_ram (
        .clk0      (clk0),
        .cs_ni     (hyper_cs_no),
        .ck_en_i   (hyper_ck_en_o),
        .dq_i      (hyper_dq_o),
        .mask_i    (hyper_rwds_o),
        .lat_i     (cfg_i.t_latency_access),
        .add_lat_i (cfg_i.en_latency_additional),
        .dq_o      (hyper_dq_i),
        .rwds_o    (hyper_rwds_i)
    );

    initial begin
        clk0 = 1'b0;
        forever #50 clk0 = ~clk0;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_rdata(input hyper_rdata_t exp, input hyper_rdata_t act);
        if (act !== exp) begin
            fail_run($sformatf(
                "Mismatch at %0t ns: rx_o expected data=%h last=%b, got data=%h last=%b",
                $time, exp.data, exp.last, act.data, act.last));
        end
    endtask

    task automatic check_resp(input logic exp, input logic act, input string name);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch at %0t ns: %s expected %b, got %b",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("Mismatch at %0t ns: %s expected %0d, got %0d",
                               $time, name, exp, act));
        end
    endtask

    // everything toward host and memory quiet while in reset
    task automatic check_reset_outputs();
        check_resp(1'b0, trans_ready_o, "trans_ready_o");
        check_resp(1'b0, tx_ready_o, "tx_ready_o");
        check_resp(1'b0, rx_valid_o, "rx_valid_o");
        check_resp(1'b0, b_valid_o, "b_valid_o");
        check_resp(1'b1, hyper_cs_no, "hyper_cs_no");
        check_resp(1'b0, hyper_ck_en_o, "hyper_ck_en_o");
        check_resp(1'b0, hyper_dq_oe_o, "hyper_dq_oe_o");
        check_resp(1'b0, hyper_rwds_oe_o, "hyper_rwds_oe_o");
    endtask

    always @(posedge clk0) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, golden list not finished", cycles));
        end
    end

    // chip select gap and accept pulses, sampled mid-cycle
    always @(negedge clk0) begin
        check_resp(rst_ni, hyper_reset_no, "hyper_reset_no");
        if (!rst_ni) begin
            check_reset_outputs();
        end else begin
            if (trans_ready_o) begin
                ready_pulses = ready_pulses + 1;
            end
            if (hyper_cs_no) begin
                cs_high_cnt = cs_high_cnt + 1;
            end else if (cs_high_cnt != 0 && cs_high_cnt < int'(rec_need)) begin
                fail_run($sformatf(
                    "chip select high for only %0d cycles at %0t ns, recovery is %0d",
                    cs_high_cnt, $time, rec_need));
            end else if (cs_high_cnt != 0) begin
                cs_high_cnt = 0;
                rec_need    = cfg_i.t_read_write_recovery;
            end
        end
    end

    task automatic scan_golden(output int words, output int n_trans);
        int p;
        p       = 0;
        words   = 0;
        n_trans = 0;
        while (p < 250 && golden[p] != 32'd0) begin
            if (golden[p] == 32'd3) begin
                p = p + 4;
            end else begin
                words   = words + int'(golden[p + 2]);
                n_trans = n_trans + 1;
                p       = p + 4 + int'(golden[p + 2]) * ((golden[p] == 32'd1) ? 2 : 1);
            end
        end
    endtask

    task automatic send_trans(input logic write, input logic [31:0] addr, input int n);
        logic taken;
        trans_i.address       = addr;
        trans_i.write         = write;
        trans_i.burst         = burst_len_t'(n - 1);
        trans_i.burst_type    = 1'b1;  // linear
        trans_i.address_space = 1'b0;
        trans_valid_i         = 1'b1;
        taken                 = 1'b0;
        while (!taken) begin
            @(negedge clk0);
            taken = trans_ready_o;
            @(posedge clk0);
            #10;
        end
        trans_valid_i = 1'b0;
    endtask

    task automatic write_burst(input logic [31:0] addr, input int n, input logic gap,
                               input int base);
        int   i;
        logic fire;
        send_trans(1'b1, addr, n);
        i = 0;
        while (i < n) begin
            tx_i.data = hyper_word_t'(golden[base + 2 * i]);
            tx_i.mask = hyper_mask_t'(golden[base + 2 * i + 1]);
            if (!tx_valid_i) begin
                tx_valid_i = !gap || (($random(seed) & 3) != 0);
            end
            @(negedge clk0);
            fire = tx_valid_i && tx_ready_o;
            check_resp(fire && (i == n - 1), b_valid_o, "b_valid_o");
            if (fire) begin
                check_resp(1'b1, hyper_dq_oe_o, "hyper_dq_oe_o");
                check_resp(1'b1, hyper_rwds_oe_o, "hyper_rwds_oe_o");
                i = i + 1;
            end
            @(posedge clk0);
            #10;
            if (fire) begin
                tx_valid_i = 1'b0;  // next beat redrawn at loop top
            end
        end
    endtask

    task automatic read_burst(input logic [31:0] addr, input int n, input logic gap,
                              input int base);
        int           i;
        hyper_rdata_t exp;
        send_trans(1'b0, addr, n);
        i = 0;
        while (i < n) begin
            rx_ready_i = !gap || (($random(seed) & 1) != 0);
            @(negedge clk0);
            check_resp(1'b0, b_valid_o, "b_valid_o");
            if (rx_valid_o && rx_ready_i) begin
                exp.data = hyper_word_t'(golden[base + i]);
                exp.last = (i == n - 1);
                check_rdata(exp, rx_o);
                check_resp(1'b0, hyper_dq_oe_o, "hyper_dq_oe_o");
                check_resp(1'b0, hyper_rwds_oe_o, "hyper_rwds_oe_o");
                i = i + 1;
            end
            @(posedge clk0);
            #10;
        end
        rx_ready_i = 1'b0;
    endtask

    initial begin
        int words;
        int n_trans;
        int pos;
        int n;
        rst_ni        = 1'b0;
        cfg_i         = '0;
        trans_i       = '0;
        trans_valid_i = 1'b0;
        tx_i          = '0;
        tx_valid_i    = 1'b0;
        rx_ready_i    = 1'b0;
        $readmemh("testbench/golden_hyper_trans.txt", golden);
        scan_golden(words, n_trans);
        cycle_limit = 40 * words + 200;

        repeat (4) @(posedge clk0);
        #10;
        rst_ni = 1'b1;

        pos = 0;
        while (golden[pos] != 32'd0) begin
            n = int'(golden[pos + 2]);
            case (golden[pos])
                32'd1: begin
                    write_burst(golden[pos + 1], n, golden[pos + 3][0], pos + 4);
                    pos = pos + 4 + 2 * n;
                end
                32'd2: begin
                    read_burst(golden[pos + 1], n, golden[pos + 3][0], pos + 4);
                    pos = pos + 4 + n;
                end
                32'd3: begin
                    cfg_i.t_latency_access      = lat_cnt_t'(golden[pos + 1]);
                    cfg_i.en_latency_additional = golden[pos + 2][0];
                    cfg_i.t_read_write_recovery = lat_cnt_t'(golden[pos + 3]);
                    pos = pos + 4;
                end
                default: fail_run($sformatf("unknown record kind %h in golden file", golden[pos]));
            endcase
        end

        check_count("trans_ready_o pulses", n_trans, ready_pulses);
        check_resp(1'b0, rx_valid_o, "rx_valid_o");
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: testbench/golden_hyper_trans.txt
// kind addr words gap, then data mask per beat (kind 1 write) or expected word (kind 2 read)
// kind 3 sets latency, additional latency and recovery; kind 0 ends the list
3 6 0 4
1 20 4 0 a1b2 0 c3d4 0 e5f6 0 0718 0
2 20 4 0 a1b2 c3d4 e5f6 0718
1 21 2 1 ffee 2 9988 1
2 20 4 1 a1b2 c3ee 99f6 0718
1 14 3 1 1357 0 2468 0 369c 0
2 14 3 0 1357 2468 369c
3 5 1 3
2 20 4 1 a1b2 c3ee 99f6 0718
1 40 8 1 8001 0 8002 0 8003 0 8004 0 8005 0 8006 0 8007 0 8008 0
2 40 8 1 8001 8002 8003 8004 8005 8006 8007 8008
1 44 1 0 7777 2
2 43 3 1 8004 8077 8006
1 15 1 0 beef 3
2 14 3 1 1357 2468 369c
0

// File: flist.f
hw/hyper_bus_pkg.sv
hw/hyper_host_pkg.sv
hw/hyper_cmd_addr.sv
hw/hyper_sequencer.sv
hw/hyper_read_path.sv
hw/hyper_phy.sv
testbench/hyper_ram_model.sv
testbench/tb_hyper_phy.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		--top-module tb_hyper_phy -Mdir obj_dir -f flist.f
	./obj_dir/Vtb_hyper_phy | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
